//--- dv/tb_luma_chroma.sv
/*
 * tb_luma_chroma
 * testbench for the composite luma/chroma encoder: drives colour and
 * sync/blank/burst levels, models the expected pins per edge and
 * compares them at the fixed four-stage latency
 */
`timescale 1ns/100ps

module tb_luma_chroma
   import video_pkg::*;
;

   localparam int     CLK_PERIOD      = 8;
   localparam level_t BLANK_LEVEL_EXP = 6'd12;  // top default
   localparam int     BURST_AMP_EXP   = 4;      // top default
   localparam int     RANDOM_CYCLES   = 2000;
   // reset, idle, b/w, saturated, sync, burst, blank, random, tail
   localparam int     STIM_CYCLES     = 8 + 8 + 40 + 48 + 20 + 32 + 16 + RANDOM_CYCLES + 8;

   typedef struct packed {
      level_t luma;
      level_t chroma;
      logic   sink;
   } expected_t;

   logic         clk_col16x_ntsc;
   logic         rst_n;
   color_index_t color;
   logic         sync;
   logic         blank;
   logic         burst;
   level_t       luma;
   level_t       chroma;
   logic         luma_sink;

   string        test_name;
   integer       seed = 32'h72;
   int           edge_cnt;    // rising edges since reset release
   int           err_cnt;
   int           check_cnt;
   expected_t    exp_q[$];    // lines model up with pipe latency
   string        name_q[$];
   level_t       sat_hist[$]; // chroma seen in the saturated run

   luma_chroma_top i_dut (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst_n           (rst_n),
      .color           (color),
      .sync            (sync),
      .blank           (blank),
      .burst           (burst),
      .luma            (luma),
      .chroma          (chroma),
      .luma_sink       (luma_sink)
   );

   initial
   begin
      clk_col16x_ntsc = 1'b0;
      forever #(CLK_PERIOD / 2) clk_col16x_ntsc = ~clk_col16x_ntsc;
   end

   // expected pins for one input pixel at subcarrier phase ph
   function automatic expected_t ref_output(color_index_t c, logic s, logic bl, logic bu,
                                            phase_t ph);
      palette_entry_t pe;
      phase_t         idx;
      int             amp_i;
      int             sin_i;
      int             swing;
      expected_t      e;
      pe = PALETTE[c];
      if (!s && bu)
      begin
         idx   = BURST_PHASE + ph;  // burst at fixed reference
         amp_i = BURST_AMP_EXP;
      end
      else
      begin
         idx   = pe.hue + ph;
         amp_i = int'(pe.amp);
      end
      sin_i = int'(SINE_LUT[idx]);
      swing = (sin_i * amp_i) >>> 2;  // floor toward minus
      if (s)
         e = '{luma: SYNC_LEVEL, chroma: CHROMA_MID, sink: 1'b1};
      else if (bu)
         e = '{luma: BLANK_LEVEL_EXP, chroma: level_t'(int'(CHROMA_MID) + swing), sink: 1'b0};
      else if (bl)
         e = '{luma: BLANK_LEVEL_EXP, chroma: CHROMA_MID, sink: 1'b0};
      else
         e = '{luma: pe.luma, chroma: level_t'(int'(CHROMA_MID) + swing), sink: 1'b0};
      return e;
   endfunction

   task automatic check_level(input string test, input string what, input level_t exp_v,
                              input level_t act_v);
      check_cnt++;
      if (exp_v !== act_v)
      begin
         err_cnt++;
         $display("ERR %s %s: expected %0d, actual %0d", test, what, exp_v, act_v);
      end
   endtask

   task automatic check_sink(input string test, input logic exp_v, input logic act_v);
      check_cnt++;
      if (exp_v !== act_v)
      begin
         err_cnt++;
         $display("ERR %s luma_sink: expected %0b, actual %0b", test, exp_v, act_v);
      end
   endtask

   // one pixel per falling edge, held for n cycles
   task automatic hold_pixel(input string name, input color_index_t c, input logic s,
                             input logic bl, input logic bu, input int n);
      repeat (n)
      begin
         @(negedge clk_col16x_ntsc);
         test_name = name;
         color     = c;
         sync      = s;
         blank     = bl;
         burst     = bu;
      end
   endtask

   // model the pixel the capture stage takes at this edge
   always @(posedge clk_col16x_ntsc)
   begin
      if (rst_n)
      begin
         edge_cnt++;
         // modulator sees sc_phase two edges later, counter starts at 0
         exp_q.push_back(ref_output(color, sync, blank, burst,
                                    phase_t'((edge_cnt + 1) % 16)));
         name_q.push_back(test_name);
      end
   end

   // outputs settle after the rising edge, so look half a cycle later
   always @(negedge clk_col16x_ntsc)
   begin
      expected_t e;
      string     name;
      if (!rst_n || exp_q.size() < 4)
      begin
         check_level("reset", "luma", BLANK_LEVEL_EXP, luma);  // pipe still idle
         check_level("reset", "chroma", CHROMA_MID, chroma);
         check_sink("reset", 1'b0, luma_sink);
      end
      else
      begin
         e    = exp_q.pop_front();
         name = name_q.pop_front();
         check_level(name, "luma", e.luma, luma);
         check_level(name, "chroma", e.chroma, chroma);
         check_sink(name, e.sink, luma_sink);
         if (name == "saturated")
         begin
            sat_hist.push_back(chroma);
            if (sat_hist.size() > 16)
               check_level(name, "period", sat_hist[sat_hist.size() - 17], chroma);
         end
      end
   end

   initial
   begin
      #((STIM_CYCLES + 100) * CLK_PERIOD);
      $display("watchdog: run did not finish within %0d cycles", STIM_CYCLES + 100);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      logic        s;
      logic        bu;
      rst_n     = 1'b0;
      color     = '0;
      sync      = 1'b0;
      blank     = 1'b1;
      burst     = 1'b0;
      test_name = "reset";
      edge_cnt  = 0;
      err_cnt   = 0;
      check_cnt = 0;

      repeat (8) @(posedge clk_col16x_ntsc);
      @(negedge clk_col16x_ntsc);
      rst_n = 1'b1;

      hold_pixel("idle", 4'd0, 1'b0, 1'b1, 1'b0, 8);
      hold_pixel("black", 4'd0, 1'b0, 1'b0, 1'b0, 20);   // flat chroma
      hold_pixel("white", 4'd1, 1'b0, 1'b0, 1'b0, 20);
      hold_pixel("saturated", 4'd2, 1'b0, 1'b0, 1'b0, 48);
      hold_pixel("sync", 4'd7, 1'b1, 1'b0, 1'b0, 8);
      hold_pixel("sync_over_blank", 4'd7, 1'b1, 1'b1, 1'b0, 4);
      hold_pixel("sync_over_burst", 4'd7, 1'b1, 1'b0, 1'b1, 4);
      hold_pixel("sync_over_all", 4'd7, 1'b1, 1'b1, 1'b1, 4);
      hold_pixel("burst", 4'd3, 1'b0, 1'b1, 1'b1, 32);   // burst beats blank
      hold_pixel("blank", 4'd5, 1'b0, 1'b1, 1'b0, 16);

      // overlap of sync and burst is left to the directed runs
      for (int i = 0; i < RANDOM_CYCLES; i++)
      begin
         r  = $random(seed);
         s  = (r[7:4] == 4'd0);
         bu = !s && (r[10:8] == 3'd0);
         hold_pixel("random", color_index_t'(r[3:0]), s, r[11], bu, 1);
      end

      hold_pixel("tail", 4'd0, 1'b0, 1'b1, 1'b0, 8);  // drain the pipe
      @(posedge clk_col16x_ntsc);  // last falling-edge compare is done by now

      $display("errors: %0d of %0d checks failed", err_cnt, check_cnt);
      if (err_cnt == 0 && check_cnt > 0)
         $display("TEST OK");
      else
      begin
         if (check_cnt == 0)
            $display("no output checks ran");
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
logic/video_pkg.sv
logic/pixel_capture.sv
logic/color_palette.sv
logic/subcarrier_phase.sv
logic/chroma_modulator.sv
logic/composite_out.sv
logic/luma_chroma_top.sv
dv/tb_luma_chroma.sv

//--- logic/chroma_modulator.sv
/*
 * chroma_modulator
 * third stage: sine lookup at hue + subcarrier phase, scaled by the
 * palette or burst amplitude and centred on the zero-chroma level
 */
`timescale 1ns/100ps

module chroma_modulator
   import video_pkg::*;
#(
   parameter amp_t BURST_AMP = 3'd4
)
(
   input  logic             clk_col16x_ntsc,
   input  logic             rst_n,
   input  shaded_pixel_t    shade,
   input  phase_t           sc_phase,
   output modulated_pixel_t mod
);

   phase_t             sine_idx;
   amp_t               amp_sel;
   logic signed [8:0]  product;
   logic signed [8:0]  scaled;
   logic signed [8:0]  chroma_sum;
   level_t             chroma_d;
   pixel_kind_e        kind_q;
   level_t             luma_q;
   level_t             chroma_q;

   always_comb
   begin
      if (shade.kind == PIX_BURST)
      begin
         sine_idx = BURST_PHASE + sc_phase;  // fixed reference phase
         amp_sel  = BURST_AMP;
      end
      else
      begin
         sine_idx = shade.pal.hue + sc_phase;  // mod 16 by width
         amp_sel  = shade.pal.amp;
      end

      product    = 9'(SINE_LUT[sine_idx]) * 9'($signed({1'b0, amp_sel}));
      scaled     = product >>> 2;  // keeps sign, floors
      chroma_sum = $signed({3'b000, CHROMA_MID}) + scaled;

      if (shade.kind == PIX_ACTIVE || shade.kind == PIX_BURST)
         chroma_d = chroma_sum[5:0];  // always positive here
      else
         chroma_d = CHROMA_MID;  // no colour in sync or blank
   end

   always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
   begin
      if (!rst_n)
         kind_q <= PIX_BLANK;
      else
         kind_q <= shade.kind;
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      luma_q   <= shade.pal.luma;
      chroma_q <= chroma_d;
   end

   assign mod = '{kind: kind_q, luma: luma_q, chroma: chroma_q};

   // palette and burst amplitudes must keep the swing off the rails
   chroma_range: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
      (mod.kind inside {PIX_ACTIVE, PIX_BURST}) |-> (mod.chroma inside {[6:58]}));

endmodule

//--- logic/color_palette.sv
/*
 * color_palette
 * second stage: looks up luma, hue phase and saturation of the
 * captured colour and registers them next to the pixel kind
 */
`timescale 1ns/100ps

module color_palette
   import video_pkg::*;
(
   input  logic            clk_col16x_ntsc,
   input  logic            rst_n,
   input  captured_pixel_t cap,
   output shaded_pixel_t   shade
);

   pixel_kind_e    kind_q;
   palette_entry_t pal_q;
   palette_entry_t pal_d;

   // table read, small enough for luts
   always_comb
   begin
      pal_d = PALETTE[cap.color];
   end

   // kind is the control path through the pipe
   always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
   begin
      if (!rst_n)
      begin
         kind_q <= PIX_BLANK;
      end
      else
      begin
         kind_q <= cap.kind;
      end
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      pal_q <= pal_d;  // luma, hue, amp together
   end

   assign shade = '{kind: kind_q, pal: pal_q};

endmodule

//--- logic/composite_out.sv
/*
 * composite_out
 * output stage: forces sync and blanking levels, keeps the burst on
 * chroma only, and registers the luma, chroma and sink pins
 */
`timescale 1ns/100ps

module composite_out
   import video_pkg::*;
#(
   parameter level_t BLANK_LEVEL = 6'd12
)
(
   input  logic             clk_col16x_ntsc,
   input  logic             rst_n,
   input  modulated_pixel_t mod,
   output level_t           luma,
   output level_t           chroma,
   output logic             luma_sink
);

   always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
   begin
      if (!rst_n)
      begin
         luma      <= BLANK_LEVEL;  // sit at blanking
         chroma    <= CHROMA_MID;
         luma_sink <= 1'b0;
      end
      else
      begin
         unique case (mod.kind)
            PIX_SYNC:
            begin
               luma      <= SYNC_LEVEL;
               chroma    <= CHROMA_MID;
               luma_sink <= 1'b1;  // pull luma below blank
            end
            PIX_BLANK:
            begin
               luma      <= BLANK_LEVEL;
               chroma    <= CHROMA_MID;
               luma_sink <= 1'b0;
            end
            PIX_BURST:
            begin
               luma      <= BLANK_LEVEL;  // burst rides on blanking
               chroma    <= mod.chroma;
               luma_sink <= 1'b0;
            end
            default:
            begin
               luma      <= mod.luma;  // active picture
               chroma    <= mod.chroma;
               luma_sink <= 1'b0;
            end
         endcase
      end
   end

   // only the sync tip may sit at the sync level, no picture or blank luma
   sink_at_sync: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
      luma_sink == (luma == SYNC_LEVEL));

endmodule

//--- logic/luma_chroma_top.sv
/*
 * luma_chroma_top
 * composite luma/chroma encoder, four register stages from colour
 * index and sync/blank/burst levels to the dac pins
 */
`timescale 1ns/100ps

module luma_chroma_top
   import video_pkg::*;
#(
   parameter level_t BLANK_LEVEL = 6'd12,  // blanking / black pedestal
   parameter amp_t   BURST_AMP   = 3'd4    // burst swing
)
(
   input  logic         clk_col16x_ntsc,
   input  logic         rst_n,
   input  color_index_t color,
   input  logic         sync,
   input  logic         blank,
   input  logic         burst,
   output level_t       luma,
   output level_t       chroma,
   output logic         luma_sink
);

   captured_pixel_t  cap;
   shaded_pixel_t    shade;
   phase_t           sc_phase;
   modulated_pixel_t mod;

   pixel_capture i_capture (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst_n           (rst_n),
      .color           (color),
      .sync            (sync),
      .blank           (blank),
      .burst           (burst),
      .cap             (cap)
   );

   color_palette i_palette (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst_n           (rst_n),
      .cap             (cap),
      .shade           (shade)
   );

   subcarrier_phase i_phase (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst_n           (rst_n),
      .sc_phase        (sc_phase)
   );

   chroma_modulator #(
      .BURST_AMP (BURST_AMP)
   ) i_modulator (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst_n           (rst_n),
      .shade           (shade),
      .sc_phase        (sc_phase),  // sampled in the modulate cycle
      .mod             (mod)
   );

   composite_out #(
      .BLANK_LEVEL (BLANK_LEVEL)
   ) i_out (
      .clk_col16x_ntsc (clk_col16x_ntsc),
      .rst_n           (rst_n),
      .mod             (mod),
      .luma            (luma),
      .chroma          (chroma),
      .luma_sink       (luma_sink)
   );

endmodule

//--- logic/pixel_capture.sv
/*
 * pixel_capture
 * input stage: registers the colour index and turns the sync, burst
 * and blank levels into one pixel kind
 */
`timescale 1ns/100ps

module pixel_capture
   import video_pkg::*;
(
   input  logic            clk_col16x_ntsc,
   input  logic            rst_n,
   input  color_index_t    color,
   input  logic            sync,
   input  logic            blank,
   input  logic            burst,
   output captured_pixel_t cap
);

   pixel_kind_e  kind_d;
   pixel_kind_e  kind_q;
   color_index_t color_q;

   // sync beats burst beats blank
   always_comb
   begin
      if (sync)
         kind_d = PIX_SYNC;
      else if (burst)
         kind_d = PIX_BURST;
      else if (blank)
         kind_d = PIX_BLANK;
      else
         kind_d = PIX_ACTIVE;
   end

   always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
   begin
      if (!rst_n)
         kind_q <= PIX_BLANK;  // idle as blanking
      else
         kind_q <= kind_d;
   end

   always_ff @(posedge clk_col16x_ntsc)
   begin
      color_q <= color;  // payload only
   end

   assign cap = '{kind: kind_q, color: color_q};

   // burst inside a sync pulse means the timing generator is off
   sync_burst_overlap: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
      !(sync && burst))
      else $warning("sync and burst asserted together, sync wins");

endmodule

//--- logic/subcarrier_phase.sv
/*
 * subcarrier_phase
 * free running subcarrier phase, one step per clock, 16 steps per
 * colour cycle
 */
`timescale 1ns/100ps

module subcarrier_phase
   import video_pkg::*;
(
   input  logic   clk_col16x_ntsc,
   input  logic   rst_n,
   output phase_t sc_phase
);

   always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sc_phase <= '0;
      end
      else
      begin
         sc_phase <= sc_phase + 4'd1;  // wraps 15 -> 0
      end
   end

   // counter must stay locked to the 16x clock
   phase_wrap: assert property (@(posedge clk_col16x_ntsc) disable iff (!rst_n)
      sc_phase == 4'd15 |=> sc_phase == 4'd0);

endmodule

//--- logic/video_pkg.sv
/*
 * video_pkg
 * shared types, stage structs and lookup tables for the composite
 * luma/chroma encoder running at 16x the NTSC subcarrier
 */
package video_pkg;

   typedef enum logic [1:0] {
      PIX_ACTIVE,  // picture area, palette driven
      PIX_BLANK,   // blanking, flat levels
      PIX_BURST,   // colour burst window
      PIX_SYNC     // sync tip
   } pixel_kind_e;

   typedef logic [3:0] color_index_t;  // palette index
   typedef logic [5:0] level_t;        // dac sample
   typedef logic [3:0] phase_t;        // 1/16 subcarrier steps
   typedef logic [2:0] amp_t;          // saturation 0..7

   typedef struct packed {
      pixel_kind_e  kind;
      color_index_t color;
   } captured_pixel_t;

   typedef struct packed {
      level_t luma;
      phase_t hue;   // phase offset vs subcarrier
      amp_t   amp;
   } palette_entry_t;

   typedef struct packed {
      pixel_kind_e    kind;
      palette_entry_t pal;
   } shaded_pixel_t;

   typedef struct packed {
      pixel_kind_e kind;
      level_t      luma;
      level_t      chroma;
   } modulated_pixel_t;

   // luma, hue, amp; amplitudes stop at 6 so chroma stays inside 6..58
   localparam palette_entry_t PALETTE [16] = '{
      '{6'd8,  4'd0,  3'd0},  // black
      '{6'd56, 4'd0,  3'd0},  // white
      '{6'd20, 4'd5,  3'd6},  // red
      '{6'd42, 4'd13, 3'd5},  // cyan
      '{6'd24, 4'd3,  3'd5},  // purple
      '{6'd34, 4'd10, 3'd5},  // green
      '{6'd16, 4'd0,  3'd6},  // blue
      '{6'd48, 4'd8,  3'd5},  // yellow
      '{6'd24, 4'd6,  3'd5},  // orange
      '{6'd16, 4'd7,  3'd4},  // brown
      '{6'd32, 4'd5,  3'd5},  // light red
      '{6'd18, 4'd0,  3'd0},  // dark grey
      '{6'd30, 4'd0,  3'd0},  // mid grey
      '{6'd48, 4'd10, 3'd5},  // light green
      '{6'd30, 4'd0,  3'd5},  // light blue
      '{6'd42, 4'd0,  3'd0}   // light grey
   };

   // one subcarrier cycle, 15 * sin(2*pi*k/16)
   localparam logic signed [4:0] SINE_LUT [16] = '{
      5'sd0,   5'sd6,   5'sd11,  5'sd14,  5'sd15,  5'sd14,  5'sd11,  5'sd6,
      5'sd0,  -5'sd6,  -5'sd11, -5'sd14, -5'sd15, -5'sd14, -5'sd11, -5'sd6
   };

   localparam level_t CHROMA_MID  = 6'd32;  // zero chroma
   localparam level_t SYNC_LEVEL  = 6'd0;
   localparam phase_t BURST_PHASE = 4'd8;   // 180 deg burst reference

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_luma_chroma \
   -o sim_luma_chroma \
   && ./obj_dir/sim_luma_chroma | tee /dev/stderr | grep -q "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
